// File: Bender.yml
package:
  name: tcdm_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/lane_pkg.sv
      - src/bank_pkg.sv
      - src/hci_mem_intf.sv
      - src/wide_port_splitter.sv
      - src/lane_bank_router.sv
      - src/tcdm_bank.sv
      - src/tcdm_subsystem.sv
      - target: test
        files:
          - testbench/tb_tcdm_subsystem.sv

// File: sources.f
+incdir+src
src/lane_pkg.sv
src/bank_pkg.sv
src/hci_mem_intf.sv
src/wide_port_splitter.sv
src/lane_bank_router.sv
src/tcdm_bank.sv
src/tcdm_subsystem.sv
testbench/tb_tcdm_subsystem.sv

// File: src/bank_pkg.sv
`include "hci_params.svh"

// memory side of the slice
package bank_pkg;

  // bits needed to address a word inside one bank
  localparam int unsigned ROW_W = $clog2(`HCI_BANK_DEPTH);

  // bank number, doubles as the lane rotation order
  typedef logic [`HCI_ORDER_W-1:0] bank_idx_t;

  // word row inside a bank
  typedef logic [ROW_W-1:0] row_t;

endpackage

// File: src/hci_mem_intf.sv
`timescale 1ns/10ps

// single word request channel, req/gnt with a fixed latency response
interface hci_mem_intf import lane_pkg::*; ();

  logic  req;
  addr_t add;
  logic  wen;   // high for read
  be_t   be;
  word_t data;
  logic  gnt;
  word_t r_data;
  logic  r_valid;

  modport initiator (
    output req, add, wen, be, data,
    input  gnt, r_data, r_valid
  );

  modport target (
    input  req, add, wen, be, data,
    output gnt, r_data, r_valid
  );

  // latency of a bank is fixed, so no r_valid here
  modport bank (
    input  req, add, wen, be, data,
    output gnt, r_data
  );

endinterface

// File: src/hci_params.svh
`ifndef HCI_PARAMS_SVH
`define HCI_PARAMS_SVH

// word lanes in one wide accelerator request
`define HCI_NB_LANES 4

// interleaved banks, power of two and not fewer than the lanes
`define HCI_NB_BANKS 8

// words held by each bank
`define HCI_BANK_DEPTH 64

// width of a bank index, also the rotation order
`define HCI_ORDER_W $clog2(`HCI_NB_BANKS)

`endif

// File: src/lane_bank_router.sv
`timescale 1ns/10ps
`include "hci_params.svh"

// rotates lanes onto interleaved banks and back
module lane_bank_router
  import lane_pkg::*, bank_pkg::*;
#(
  parameter int unsigned FILTER_WRITE_R_VALID = 0 // set to drop r_valid on writes
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  bank_idx_t order_i,

  hci_mem_intf.target    lanes [`HCI_NB_LANES],
  hci_mem_intf.initiator banks [`HCI_NB_BANKS]
);

  logic      [`HCI_NB_LANES-1:0] lane_req;
  logic      [`HCI_NB_LANES-1:0] lane_wen;
  addr_t     [`HCI_NB_LANES-1:0] lane_add;
  be_t       [`HCI_NB_LANES-1:0] lane_be;
  word_t     [`HCI_NB_LANES-1:0] lane_data;
  bank_idx_t [`HCI_NB_LANES-1:0] lane_bank; // target bank of each lane
  bank_idx_t [`HCI_NB_LANES-1:0] rd_bank;   // source bank of each response

  logic  [`HCI_NB_BANKS-1:0] bank_req;
  logic  [`HCI_NB_BANKS-1:0] bank_wen;
  logic  [`HCI_NB_BANKS-1:0] bank_gnt;
  addr_t [`HCI_NB_BANKS-1:0] bank_add;
  be_t   [`HCI_NB_BANKS-1:0] bank_be;
  word_t [`HCI_NB_BANKS-1:0] bank_data;
  word_t [`HCI_NB_BANKS-1:0] bank_r_data;

  logic [`HCI_NB_LANES-1:0][`HCI_NB_BANKS-1:0] sel;

  logic      wide_gnt;
  logic      accept;
  logic      rd_q;    // response due this cycle
  bank_idx_t order_q; // rotation of the request in flight

  // granted only if every touched bank grants
  assign wide_gnt = &(~bank_req | bank_gnt);
  assign accept   = lane_req[0] & wide_gnt;

  generate
    for (genvar i = 0; i < `HCI_NB_LANES; i++) begin : lane_gen
      assign lane_req[i]  = lanes[i].req;
      assign lane_wen[i]  = lanes[i].wen;
      assign lane_add[i]  = lanes[i].add;
      assign lane_be[i]   = lanes[i].be;
      assign lane_data[i] = lanes[i].data;

      assign lane_bank[i] = order_i + bank_idx_t'(i);
      assign rd_bank[i]   = order_q + bank_idx_t'(i);

      assign lanes[i].gnt     = wide_gnt;
      assign lanes[i].r_valid = rd_q;    // latency is always one
      assign lanes[i].r_data  = bank_r_data[rd_bank[i]];
    end

    for (genvar b = 0; b < `HCI_NB_BANKS; b++) begin : bank_gen
      assign banks[b].req  = bank_req[b] & wide_gnt; // held back until all touched banks grant
      assign banks[b].add  = bank_add[b];
      assign banks[b].wen  = bank_wen[b];
      assign banks[b].be   = bank_be[b];
      assign banks[b].data = bank_data[b];

      assign bank_gnt[b]    = banks[b].gnt;
      assign bank_r_data[b] = banks[b].r_data;
    end
  endgenerate

  // lane to bank selection matrix
  always_comb begin
    for (int j = 0; j < `HCI_NB_LANES; j++) begin
      for (int b = 0; b < `HCI_NB_BANKS; b++) begin
        sel[j][b] = lane_req[j] && (lane_bank[j] == bank_idx_t'(b));
      end
    end
  end

  // each bank sees the OR of the at most one lane selecting it
  always_comb begin
    bank_req  = '0;
    bank_wen  = '0;
    bank_add  = '0;
    bank_be   = '0;
    bank_data = '0;
    for (int b = 0; b < `HCI_NB_BANKS; b++) begin
      for (int j = 0; j < `HCI_NB_LANES; j++) begin
        bank_req[b]  |= sel[j][b];
        bank_wen[b]  |= sel[j][b] & lane_wen[j];
        bank_add[b]  |= sel[j][b] ? (lane_add[j] >> 2) : '0; // word address
        bank_be[b]   |= sel[j][b] ? lane_be[j] : '0;
        bank_data[b] |= sel[j][b] ? lane_data[j] : '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q    <= 1'b0;
      order_q <= '0;
    end else if (clear_i) begin
      rd_q    <= 1'b0;
      order_q <= '0;
    end else begin
      rd_q <= accept & ((FILTER_WRITE_R_VALID != 0) ? lane_wen[0] : 1'b1);
      if (accept) begin
        order_q <= order_i;
      end
    end
  end

endmodule

// File: src/lane_pkg.sv
`include "hci_params.svh"

// accelerator side of the memory slice
package lane_pkg;

  // byte address, word aligned in practice
  typedef logic [31:0] addr_t;

  typedef logic [31:0] word_t;

  // one enable bit per byte of a word
  typedef logic [3:0] be_t;

  // wide vectors, lane 0 in the low bits
  typedef word_t [`HCI_NB_LANES-1:0] wide_data_t;
  typedef be_t [`HCI_NB_LANES-1:0] wide_be_t;

endpackage

// File: src/tcdm_bank.sv
`timescale 1ns/10ps
`include "hci_params.svh"

// one single-port word memory, byte enables on write
module tcdm_bank
  import lane_pkg::*, bank_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic busy_i, // bank taken by someone else

  hci_mem_intf.bank port
);

  word_t mem [`HCI_BANK_DEPTH];
  row_t  row;
  logic  accept;

  // interleaved by word, so the low bits pick the bank
  assign row    = port.add[`HCI_ORDER_W +: ROW_W];
  assign port.gnt = ~busy_i;
  assign accept = port.req & ~busy_i;

  // write lands at the edge of acceptance
  always_ff @(posedge clk_i) begin
    if (accept && !port.wen) begin
      for (int k = 0; k < 4; k++) begin
        if (port.be[k]) begin
          mem[row][8*k +: 8] <= port.data[8*k +: 8];
        end
      end
    end
  end

  // read word comes out one cycle later, held otherwise
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      port.r_data <= '0;
    end else if (accept && port.wen) begin
      port.r_data <= mem[row];
    end
  end

endmodule

// File: src/tcdm_subsystem.sv
`timescale 1ns/10ps
`include "hci_params.svh"

// splitter, router and bank array behind one wide port
module tcdm_subsystem
  import lane_pkg::*, bank_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,

  input  logic                     req_i,
  input  logic                     wen_i,   // high for read
  input  addr_t                    addr_i,
  input  wide_be_t                 be_i,
  input  wide_data_t               wdata_i,
  input  logic [`HCI_NB_BANKS-1:0] bank_busy_i,

  output logic                     gnt_o,
  output logic                     r_valid_o,
  output wide_data_t               rdata_o
);

  bank_idx_t order; // bank of the first word

  hci_mem_intf lane_if [`HCI_NB_LANES] ();
  hci_mem_intf bank_if [`HCI_NB_BANKS] ();

  wide_port_splitter wide_port_splitter_inst (
    .req_i     ( req_i     ),
    .wen_i     ( wen_i     ),
    .addr_i    ( addr_i    ),
    .be_i      ( be_i      ),
    .wdata_i   ( wdata_i   ),
    .gnt_o     ( gnt_o     ),
    .r_valid_o ( r_valid_o ),
    .rdata_o   ( rdata_o   ),
    .order_o   ( order     ),
    .lanes     ( lane_if   )
  );

  lane_bank_router #(
    .FILTER_WRITE_R_VALID ( 1 )
  ) lane_bank_router_inst (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .clear_i ( clear_i ),
    .order_i ( order   ),
    .lanes   ( lane_if ),
    .banks   ( bank_if )
  );

  generate
    for (genvar b = 0; b < `HCI_NB_BANKS; b++) begin : bank_gen
      tcdm_bank tcdm_bank_inst (
        .clk_i  ( clk_i          ),
        .rst_ni ( rst_ni         ),
        .busy_i ( bank_busy_i[b] ),
        .port   ( bank_if[b]     )
      );
    end
  endgenerate

endmodule

// File: src/wide_port_splitter.sv
`timescale 1ns/10ps
`include "hci_params.svh"

// breaks one wide request into per-word lane requests
module wide_port_splitter
  import lane_pkg::*, bank_pkg::*;
(
  input  logic       req_i,
  input  logic       wen_i,
  input  addr_t      addr_i,
  input  wide_be_t   be_i,
  input  wide_data_t wdata_i,
  output logic       gnt_o,
  output logic       r_valid_o,
  output wide_data_t rdata_o,
  output bank_idx_t  order_o,

  hci_mem_intf.initiator lanes [`HCI_NB_LANES]
);

  // bank of the first word, bits above the byte offset
  assign order_o = addr_i[2 +: `HCI_ORDER_W];

  generate
    for (genvar i = 0; i < `HCI_NB_LANES; i++) begin : lane_gen
      addr_t lane_add;

      assign lane_add = addr_i + addr_t'(4 * i); // byte address of word i

      assign lanes[i].req  = req_i;
      assign lanes[i].wen  = wen_i;
      assign lanes[i].add  = lane_add;
      assign lanes[i].be   = be_i[i];
      assign lanes[i].data = wdata_i[i];

      assign rdata_o[i] = lanes[i].r_data;
    end
  endgenerate

  // lanes move in lockstep, lane 0 speaks for all of them
  assign gnt_o     = lanes[0].gnt;
  assign r_valid_o = lanes[0].r_valid;

endmodule

// File: testbench/tb_tcdm_subsystem.sv
`timescale 1ns/10ps
`include "hci_params.svh"

module tb_tcdm_subsystem
  import lane_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int NUM_OPS      = 27; // wide operations issued by the tests
  localparam int MEM_WORDS    = `HCI_NB_BANKS * `HCI_BANK_DEPTH;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     clear_i;
  logic                     req_i;
  logic                     wen_i;
  addr_t                    addr_i;
  wide_be_t                 be_i;
  wide_data_t               wdata_i;
  logic [`HCI_NB_BANKS-1:0] bank_busy_i;
  logic                     gnt_o;
  logic                     r_valid_o;
  wide_data_t               rdata_o;

  word_t       ref_mem [MEM_WORDS]; // one word per global word address
  logic [15:0] lfsr_state;

  tcdm_subsystem tcdm_subsystem_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .req_i       ( req_i       ),
    .wen_i       ( wen_i       ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .bank_busy_i ( bank_busy_i ),
    .gnt_o       ( gnt_o       ),
    .r_valid_o   ( r_valid_o   ),
    .rdata_o     ( rdata_o     )
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic word_t rand_word();
    word_t w;
    for (int k = 0; k < 32; k++) begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      w[k] = lfsr_state[0];
    end
    return w;
  endfunction

  function automatic wide_data_t rand_wide();
    wide_data_t d;
    for (int i = 0; i < `HCI_NB_LANES; i++) begin
      d[i] = rand_word();
    end
    return d;
  endfunction

  function automatic void model_write(input addr_t addr, input wide_be_t be,
                                      input wide_data_t data);
    int w;
    for (int i = 0; i < `HCI_NB_LANES; i++) begin
      w = int'(addr >> 2) + i;
      for (int k = 0; k < 4; k++) begin
        if (be[i][k]) ref_mem[w][8*k +: 8] = data[i][8*k +: 8];
      end
    end
  endfunction

  task automatic set_request(input logic wen, input addr_t addr, input wide_be_t be,
                             input wide_data_t data);
    req_i   <= 1'b1;
    wen_i   <= wen;
    addr_i  <= addr;
    be_i    <= be;
    wdata_i <= data;
  endtask

  // called at a falling edge and returns there with gnt_o high
  task automatic wait_grant(output int waits);
    waits = 0;
    while (!gnt_o) begin
      waits++;
      @(negedge clk_i);
    end
  endtask

  task automatic check_lanes(input addr_t addr);
    for (int i = 0; i < `HCI_NB_LANES; i++) begin
      check_word($sformatf("rdata_o[%0d]", i), rdata_o[i], ref_mem[int'(addr >> 2) + i]);
    end
  endtask

  task automatic do_write(input addr_t addr, input wide_be_t be, input wide_data_t data,
                          output int waits);
    @(posedge clk_i);
    set_request(1'b0, addr, be, data);
    @(negedge clk_i);
    wait_grant(waits);
    model_write(addr, be, data);
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    check_word("r_valid_o", r_valid_o, 1'b0); // writes give no response
  endtask

  task automatic do_read(input addr_t addr);
    int waits;
    @(posedge clk_i);
    set_request(1'b1, addr, '0, '0);
    @(negedge clk_i);
    wait_grant(waits);
    check_word("r_valid_o", r_valid_o, 1'b0);
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    check_word("r_valid_o", r_valid_o, 1'b1);
    check_lanes(addr);
  endtask

  // one read per cycle with each response checked while the next is granted
  task automatic read_burst(input addr_t base, input int n);
    int waits;
    @(posedge clk_i);
    set_request(1'b1, base, '0, '0);
    @(negedge clk_i);
    wait_grant(waits);
    for (int k = 0; k < n; k++) begin
      @(posedge clk_i);
      if (k < n - 1) set_request(1'b1, base + addr_t'(16 * (k + 1)), '0, '0);
      else req_i <= 1'b0;
      @(negedge clk_i);
      check_word("r_valid_o", r_valid_o, 1'b1);
      check_lanes(base + addr_t'(16 * k));
      if (k < n - 1) wait_grant(waits);
    end
  endtask

  // write at 0x88 touches banks 2..5 while bank 4 is held busy for three cycles
  task automatic stall_touched_bank();
    wide_data_t d;
    int waits;
    d = rand_wide();
    @(posedge clk_i);
    bank_busy_i <= 8'h10;
    set_request(1'b0, 32'h88, '1, d);
    for (int k = 0; k < 3; k++) begin
      @(negedge clk_i);
      assert (gnt_o === 1'b0) else begin
        $display("gnt_o went high while a touched bank was busy");
        abort_run();
      end
      check_word("bank 2 row 4", tcdm_subsystem_inst.bank_gen[2].tcdm_bank_inst.mem[4],
                 ref_mem[34]);
    end
    @(posedge clk_i);
    bank_busy_i <= '0;
    @(negedge clk_i);
    wait_grant(waits);
    model_write(32'h88, '1, d);
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    check_word("r_valid_o", r_valid_o, 1'b0);
  endtask

  task automatic clear_drops_read(input addr_t addr);
    int waits;
    @(posedge clk_i);
    set_request(1'b1, addr, '0, '0);
    clear_i <= 1'b1;
    @(negedge clk_i);
    wait_grant(waits);
    @(posedge clk_i);
    req_i   <= 1'b0;
    clear_i <= 1'b0;
    @(negedge clk_i);
    check_word("r_valid_o", r_valid_o, 1'b0);
  endtask

  initial begin
    repeat (RESET_CYCLES + NUM_OPS * 40 + 50) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    abort_run();
  end

  initial begin
    int waits;
    lfsr_state  = 16'd37351;
    rst_ni      <= 1'b0;
    clear_i     <= 1'b0;
    req_i       <= 1'b0;
    wen_i       <= 1'b0;
    addr_i      <= '0;
    be_i        <= '0;
    wdata_i     <= '0;
    bank_busy_i <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(negedge clk_i);
    check_word("r_valid_o", r_valid_o, 1'b0);
    check_word("gnt_o", gnt_o, 1'b1);

    do_write(32'h00, '1, rand_wide(), waits); // bank offset 0
    do_read(32'h00);

    // neighbouring wide words hold known data before the wrap writes
    do_write(32'h10, '1, rand_wide(), waits);
    do_write(32'h20, '1, rand_wide(), waits);
    do_write(32'h30, '1, rand_wide(), waits);

    // starts at banks 5, 6 and 7 and wraps into row 1
    do_write(32'h14, '1, rand_wide(), waits);
    do_write(32'h18, '1, rand_wide(), waits);
    do_write(32'h1c, '1, rand_wide(), waits);
    do_read(32'h14);
    do_read(32'h18);
    do_read(32'h1c);
    do_read(32'h00);
    do_read(32'h20);

    do_write(32'h40, '1, rand_wide(), waits);
    do_write(32'h40, 16'h60f9, rand_wide(), waits); // mixed byte enables
    do_read(32'h40);

    do_write(32'h88, '1, rand_wide(), waits);
    stall_touched_bank();
    do_read(32'h88);
    @(posedge clk_i);
    bank_busy_i <= 8'h80; // bank 7 is not touched
    do_write(32'h88, '1, rand_wide(), waits);
    check_word("stall cycles", waits, 0);
    @(posedge clk_i);
    bank_busy_i <= '0;
    do_read(32'h88);

    read_burst(32'h00, 4);
    clear_drops_read(32'h20);
    do_read(32'h20);

    $display("Everything OK");
    $finish;
  end

endmodule
